// ==== src.f ====
hdl/x86_types_pkg.sv
hdl/rrag_cfg_pkg.sv
hdl/size_decode.sv
hdl/reg_file.sv
hdl/seg_file.sv
hdl/addr_gen.sv
hdl/issue_ctrl.sv
hdl/result_reg.sv
hdl/rrag_top.sv
sim/rrag_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= rrag_tb
DUT_TOP   ?= rrag_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/rrag_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rrag_tb
    import x86_types_pkg::*, rrag_cfg_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int RAND_CYCLES  = 400;
    // Reset, register fill, random traffic and the directed sequences.
    localparam int TEST_CYCLES  = RESET_CYCLES + NUM_GPR + RAND_CYCLES + 24;

    logic       clk, reset, flush, valid_in, hold, wb_en, seg_wb_en;
    logic       mem_use, use_base, use_index, dest_ld;
    reg_idx_t   wb_idx, seg_wb_idx, base_idx, index_idx, dest_reg, data_idx, seg_idx;
    opsize_t    wb_size, opsize, size_q;
    scale_t     scale;
    logic [3:0] mem_size_ovr;
    word_t      wb_data, disp, mem_addr_q, mem_addr_end_q, data_q;
    seg_t       seg_wb_data, seg_q;
    logic       stall, valid_out, fault_q;

    // Shadow copy of the register state and the results predicted from it.
    word_t              m_regs [NUM_GPR];
    seg_t               m_segs [NUM_SEG];
    logic [NUM_GPR-1:0] m_pend;
    logic               exp_stall, exp_valid, exp_fault, check_en, last_stall;
    word_t              exp_addr, exp_end, exp_data;
    seg_t               exp_seg;
    opsize_t            exp_size;
    word_t              lcg_state;

    rrag_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 100 + 1000);
        $display("Watchdog timeout: the test sequence did not finish in time.");
        $display("TEST FAIL");
        $fatal(1, "Simulation timed out");
    end

    function automatic word_t next_random();
        word_t upper;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        upper = lcg_state;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {upper[31:16], lcg_state[31:16]};
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "Check failed");
    endtask

    // Works out the response to this cycle's inputs and then applies the writes
    // that the DUT takes at the next rising edge.
    task automatic predict();
        opsize_t eff;
        word_t   span;
        word_t   offset;
        word_t   addr;
        logic    stall_m;
        logic    accept_m;
        eff = opsize;
        for (int b = 3; b >= 0; b--) begin
            if (mem_size_ovr[b]) eff = opsize_t'(b);
        end
        span = word_t'(1) << eff;
        offset = disp;
        if (use_base) offset = offset + m_regs[base_idx];
        if (use_index) offset = offset + (m_regs[index_idx] << scale);
        addr = offset + {m_segs[seg_idx], 16'h0000};
        stall_m = valid_in && (hold || (dest_ld && m_pend[dest_reg]) ||
                  (mem_use && ((use_base && m_pend[base_idx]) ||
                               (use_index && m_pend[index_idx]))));
        accept_m = valid_in && !stall_m;
        exp_stall <= stall_m;
        exp_valid <= accept_m;
        if (accept_m) begin
            exp_addr  <= addr;
            exp_end   <= addr + span - 32'd1;
            exp_data  <= m_regs[data_idx];
            exp_seg   <= m_segs[seg_idx];
            exp_fault <= mem_use && (offset + span - 32'd1 > word_t'(SEG_LIM_RESET[seg_idx]));
            exp_size  <= eff;
        end
        last_stall = stall_m;
        if (wb_en) begin
            case (wb_size)
                SIZE_BYTE: m_regs[wb_idx][7:0] = wb_data[7:0];
                SIZE_WORD: m_regs[wb_idx][15:0] = wb_data[15:0];
                default:   m_regs[wb_idx] = wb_data;
            endcase
            m_pend[wb_idx] = 1'b0;
        end
        if (accept_m && dest_ld) m_pend[dest_reg] = 1'b1;
        if (flush) m_pend = '0;
        if (seg_wb_en) m_segs[seg_wb_idx] = seg_wb_data;
    endtask

    task automatic run_cycle();
        predict();
        @(negedge clk);
    endtask

    task automatic clear_controls();
        flush = 1'b0;
        valid_in = 1'b0;
        hold = 1'b0;
        wb_en = 1'b0;
        seg_wb_en = 1'b0;
        mem_use = 1'b0;
        use_base = 1'b0;
        use_index = 1'b0;
        dest_ld = 1'b0;
        mem_size_ovr = 4'b0000;
    endtask

    // A stalled instruction stays on the inputs while writebacks keep changing.
    task automatic randomize_inputs(input logic keep_instr);
        word_t r;
        word_t s;
        r = next_random();
        s = next_random();
        wb_en = r[0];
        wb_idx = r[3:1];
        wb_size = r[5:4];
        seg_wb_en = r[8:6] == 3'b000;
        seg_wb_idx = r[11:9];
        hold = r[15:12] == 4'b0000;
        flush = r[21:16] == 6'b000000;
        wb_data = s;
        seg_wb_data = s[31:16];
        if (!keep_instr) begin
            r = next_random();
            s = next_random();
            valid_in = r[1:0] != 2'b00;
            mem_use = r[4:2] != 3'b000;
            use_base = r[5];
            use_index = r[6];
            base_idx = r[9:7];
            index_idx = r[12:10];
            data_idx = r[15:13];
            seg_idx = r[18:16];
            scale = r[20:19];
            opsize = r[22:21];
            mem_size_ovr = r[23] ? r[27:24] : 4'b0000;
            dest_ld = r[29:28] == 2'b00;
            dest_reg = s[2:0];
            disp = s[3] ? s : {20'h00000, s[15:4]};
        end
    endtask

    // Stall follows the inputs driven at the previous falling edge.
    stall_check: assert property (@(posedge clk) disable iff (!check_en)
        stall == exp_stall)
        else report_error($sformatf("stall is %b, expected %b", stall, exp_stall));

    valid_check: assert property (@(negedge clk) disable iff (!check_en)
        valid_out == exp_valid)
        else report_error($sformatf("valid_out is %b, expected %b", valid_out, exp_valid));

    result_check: assert property (@(negedge clk) disable iff (!check_en)
        !exp_valid || (mem_addr_q == exp_addr && mem_addr_end_q == exp_end &&
                       data_q == exp_data && seg_q == exp_seg &&
                       fault_q == exp_fault && size_q == exp_size))
        else report_error($sformatf(
            "result %h %h %h %h %b %0d, expected %h %h %h %h %b %0d",
            mem_addr_q, mem_addr_end_q, data_q, seg_q, fault_q, size_q,
            exp_addr, exp_end, exp_data, exp_seg, exp_fault, exp_size));

    initial begin
        lcg_state = 32'd64;
        check_en = 1'b0;
        last_stall = 1'b0;
        exp_valid <= 1'b0;
        exp_stall <= 1'b0;
        m_pend = '0;
        for (int i = 0; i < NUM_GPR; i++) begin
            m_regs[i] = '0;
            m_segs[i] = '0;
        end
        randomize_inputs(1'b0);
        clear_controls();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_en = 1'b1;

        for (int i = 0; i < NUM_GPR; i++) begin
            randomize_inputs(1'b0);
            clear_controls();
            wb_en = 1'b1;
            wb_idx = reg_idx_t'(i);
            wb_size = SIZE_DWORD;
            seg_wb_en = 1'b1;
            seg_wb_idx = reg_idx_t'(i);
            run_cycle();
        end
        for (int c = 0; c < RAND_CYCLES; c++) begin
            randomize_inputs(last_stall);
            run_cycle();
        end

        // A dword ending exactly on the limit of segment 6 and then one byte past it.
        clear_controls();
        flush = 1'b1;
        run_cycle();
        flush = 1'b0;
        valid_in = 1'b1;
        mem_use = 1'b1;
        seg_idx = 3'd6;
        opsize = SIZE_DWORD;
        disp = word_t'(SEG_LIM_RESET[6]) - 32'd3;
        run_cycle();
        disp = disp + 32'd1;
        run_cycle();

        // Load into r3 and use r3 as a base until a byte writeback arrives.
        mem_use = 1'b0;
        dest_ld = 1'b1;
        dest_reg = 3'd3;
        run_cycle();
        dest_ld = 1'b0;
        mem_use = 1'b1;
        use_base = 1'b1;
        base_idx = 3'd3;
        data_idx = 3'd3;
        seg_idx = 3'd1;
        repeat (2) run_cycle();
        wb_en = 1'b1;
        wb_idx = 3'd3;
        wb_size = SIZE_BYTE;
        wb_data = 32'hffff_ff5a;
        run_cycle();
        wb_en = 1'b0;
        run_cycle();

        // Back-pressure and then a stall on a pending index that only a flush releases.
        hold = 1'b1;
        repeat (3) run_cycle();
        hold = 1'b0;
        dest_ld = 1'b1;
        dest_reg = 3'd5;
        use_base = 1'b0;
        run_cycle();
        dest_ld = 1'b0;
        use_index = 1'b1;
        index_idx = 3'd5;
        scale = 2'd2;
        run_cycle();
        flush = 1'b1;
        run_cycle();
        flush = 1'b0;
        run_cycle();
        clear_controls();
        repeat (2) run_cycle();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/rrag_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rrag_top
    import x86_types_pkg::*, rrag_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       valid_in,
    input  logic       hold,
    input  logic       wb_en,
    input  reg_idx_t   wb_idx,
    input  opsize_t    wb_size,
    input  word_t      wb_data,
    input  logic       seg_wb_en,
    input  reg_idx_t   seg_wb_idx,
    input  seg_t       seg_wb_data,
    input  opsize_t    opsize,
    input  logic [3:0] mem_size_ovr,
    input  logic       mem_use,
    input  logic       use_base,
    input  logic       use_index,
    input  reg_idx_t   base_idx,
    input  reg_idx_t   index_idx,
    input  scale_t     scale,
    input  word_t      disp,
    input  logic       dest_ld,
    input  reg_idx_t   dest_reg,
    input  reg_idx_t   data_idx,
    input  reg_idx_t   seg_idx,
    output logic       stall,
    output logic       valid_out,
    output word_t      mem_addr_q,
    output word_t      mem_addr_end_q,
    output word_t      data_q,
    output seg_t       seg_q,
    output logic       fault_q,
    output opsize_t    size_q
);

    opsize_t            eff_size;
    word_t              span_m1;
    word_t              base_val;
    word_t              index_val;
    word_t              data_val;
    logic [NUM_GPR-1:0] pending;
    seg_t               seg_val;
    lim_t               seg_lim;
    word_t              mem_addr;
    word_t              mem_addr_end;
    logic               fault;
    logic               accept;
    logic               set_en;

    // Only an accepted load marks its destination as waiting for writeback.
    assign set_en = accept && dest_ld;

    size_decode i_size_decode (
        .opsize(opsize), .mem_size_ovr(mem_size_ovr),
        .eff_size(eff_size), .span_m1(span_m1)
    );

    reg_file i_reg_file (
        .clk(clk), .reset(reset), .flush(flush),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_size(wb_size), .wb_data(wb_data),
        .set_en(set_en), .set_idx(dest_reg),
        .base_idx(base_idx), .index_idx(index_idx), .data_idx(data_idx),
        .base_val(base_val), .index_val(index_val), .data_val(data_val),
        .pending(pending)
    );

    seg_file i_seg_file (
        .clk(clk), .reset(reset),
        .seg_wb_en(seg_wb_en), .seg_wb_idx(seg_wb_idx), .seg_wb_data(seg_wb_data),
        .seg_idx(seg_idx), .seg_val(seg_val), .seg_lim(seg_lim)
    );

    addr_gen i_addr_gen (
        .base_val(base_val), .index_val(index_val), .disp(disp),
        .use_base(use_base), .use_index(use_index), .scale(scale),
        .seg_val(seg_val), .seg_lim(seg_lim), .span_m1(span_m1), .mem_use(mem_use),
        .mem_addr(mem_addr), .mem_addr_end(mem_addr_end), .fault(fault)
    );

    issue_ctrl i_issue_ctrl (
        .valid_in(valid_in), .hold(hold), .mem_use(mem_use),
        .use_base(use_base), .use_index(use_index),
        .base_idx(base_idx), .index_idx(index_idx),
        .dest_ld(dest_ld), .dest_reg(dest_reg), .pending(pending),
        .stall(stall), .accept(accept)
    );

    result_reg i_result_reg (
        .clk(clk), .reset(reset), .accept(accept),
        .mem_addr(mem_addr), .mem_addr_end(mem_addr_end), .data_val(data_val),
        .seg_val(seg_val), .fault(fault), .eff_size(eff_size),
        .valid_out(valid_out), .mem_addr_q(mem_addr_q), .mem_addr_end_q(mem_addr_end_q),
        .data_q(data_q), .seg_q(seg_q), .fault_q(fault_q), .size_q(size_q)
    );

endmodule

`default_nettype wire

// ==== hdl/result_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_reg
    import x86_types_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    accept,
    input  word_t   mem_addr,
    input  word_t   mem_addr_end,
    input  word_t   data_val,
    input  seg_t    seg_val,
    input  logic    fault,
    input  opsize_t eff_size,
    output logic    valid_out,
    output word_t   mem_addr_q,
    output word_t   mem_addr_end_q,
    output word_t   data_q,
    output seg_t    seg_q,
    output logic    fault_q,
    output opsize_t size_q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= accept;
        end
    end

    // Payload keeps its value between accepts, valid_out qualifies it.
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr_q     <= mem_addr;
            mem_addr_end_q <= mem_addr_end;
            data_q         <= data_val;
            seg_q          <= seg_val;
            fault_q        <= fault;
            size_q         <= eff_size;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl
    import x86_types_pkg::*, rrag_cfg_pkg::*;
(
    input  logic               valid_in,
    input  logic               hold,
    input  logic               mem_use,
    input  logic               use_base,
    input  logic               use_index,
    input  reg_idx_t           base_idx,
    input  reg_idx_t           index_idx,
    input  logic               dest_ld,
    input  reg_idx_t           dest_reg,
    input  logic [NUM_GPR-1:0] pending,
    output logic               stall,
    output logic               accept
);

    logic addr_wait;
    logic dest_wait;

    // Only operands that feed the address can hold up the instruction.
    assign addr_wait = mem_use && ((use_base && pending[base_idx]) ||
                                   (use_index && pending[index_idx]));
    assign dest_wait = dest_ld && pending[dest_reg];

    assign stall  = valid_in && (hold || addr_wait || dest_wait);
    assign accept = valid_in && !stall;

endmodule

`default_nettype wire

// ==== hdl/addr_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module addr_gen
    import x86_types_pkg::*;
(
    input  word_t  base_val,
    input  word_t  index_val,
    input  word_t  disp,
    input  logic   use_base,
    input  logic   use_index,
    input  scale_t scale,
    input  seg_t   seg_val,
    input  lim_t   seg_lim,
    input  word_t  span_m1,
    input  logic   mem_use,
    output word_t  mem_addr,
    output word_t  mem_addr_end,
    output logic   fault
);

    word_t base_term;
    word_t index_term;
    word_t offset;
    word_t offset_end;

    assign base_term  = use_base ? base_val : '0;
    assign index_term = use_index ? (index_val << scale) : '0;
    assign offset     = disp + base_term + index_term;

    // The segment value acts as a base shifted up by 16.
    assign mem_addr     = offset + {seg_val, 16'h0000};
    assign mem_addr_end = mem_addr + span_m1;

    // The last byte of the access must lie within the limit.
    assign offset_end = offset + span_m1;
    assign fault      = mem_use && (offset_end > word_t'(seg_lim));

endmodule

`default_nettype wire

// ==== hdl/seg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module seg_file
    import x86_types_pkg::*, rrag_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     seg_wb_en,
    input  reg_idx_t seg_wb_idx,
    input  seg_t     seg_wb_data,
    input  reg_idx_t seg_idx,
    output seg_t     seg_val,
    output lim_t     seg_lim
);

    seg_t segs [NUM_SEG];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SEG; i++) begin
                segs[i] <= '0;
            end
        end else if (seg_wb_en) begin
            segs[seg_wb_idx] <= seg_wb_data;
        end
    end

    // Each segment keeps the limit it was given at reset.
    assign seg_val = segs[seg_idx];
    assign seg_lim = SEG_LIM_RESET[seg_idx];

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import x86_types_pkg::*, rrag_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               wb_en,
    input  reg_idx_t           wb_idx,
    input  opsize_t            wb_size,
    input  word_t              wb_data,
    input  logic               set_en,
    input  reg_idx_t           set_idx,
    input  reg_idx_t           base_idx,
    input  reg_idx_t           index_idx,
    input  reg_idx_t           data_idx,
    output word_t              base_val,
    output word_t              index_val,
    output word_t              data_val,
    output logic [NUM_GPR-1:0] pending
);

    word_t regs [NUM_GPR];

    // Narrow writebacks only replace the low bytes of the register.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            case (wb_size)
                SIZE_BYTE: regs[wb_idx][7:0]  <= wb_data[7:0];
                SIZE_WORD: regs[wb_idx][15:0] <= wb_data[15:0];
                default:   regs[wb_idx]       <= wb_data;
            endcase
        end
    end

    // The set comes last, so a new issue wins over a writeback to the same register.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pending <= '0;
        end else begin
            if (wb_en) begin
                pending[wb_idx] <= 1'b0;
            end
            if (set_en) begin
                pending[set_idx] <= 1'b1;
            end
        end
    end

    assign base_val  = regs[base_idx];
    assign index_val = regs[index_idx];
    assign data_val  = regs[data_idx];

endmodule

`default_nettype wire

// ==== hdl/size_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module size_decode
    import x86_types_pkg::*, rrag_cfg_pkg::*;
(
    input  opsize_t    opsize,
    input  logic [3:0] mem_size_ovr,
    output opsize_t    eff_size,
    output word_t      span_m1
);

    // The lowest set override bit wins over the instruction's operand size.
    always_comb begin
        if (mem_size_ovr[0]) begin
            eff_size = SIZE_BYTE;
        end else if (mem_size_ovr[1]) begin
            eff_size = SIZE_WORD;
        end else if (mem_size_ovr[2]) begin
            eff_size = SIZE_DWORD;
        end else if (mem_size_ovr[3]) begin
            eff_size = SIZE_QUAD;
        end else begin
            eff_size = opsize;
        end
    end

    // The span is 1, 2, 4 or 8 bytes, a power of two given by the size code.
    always_comb begin
        span_m1 = (word_t'(1) << eff_size) - word_t'(1);
    end

endmodule

`default_nettype wire

// ==== hdl/rrag_cfg_pkg.sv ====
`default_nettype none

package rrag_cfg_pkg;
    import x86_types_pkg::*;

    localparam int NUM_GPR = 8;
    localparam int NUM_SEG = 8;

    // Limits loaded into the segment file on reset, indexed by segment number.
    localparam lim_t SEG_LIM_RESET [NUM_SEG] = '{
        20'h0ffff, 20'hfffff, 20'h0ffff, 20'h0ffff,
        20'h003ff, 20'h00fff, 20'h000ff, 20'h00000
    };

    localparam opsize_t SIZE_BYTE  = 2'd0;
    localparam opsize_t SIZE_WORD  = 2'd1;
    localparam opsize_t SIZE_DWORD = 2'd2;
    localparam opsize_t SIZE_QUAD  = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/x86_types_pkg.sv ====
`default_nettype none

package x86_types_pkg;

    // Register values and linear addresses.
    typedef logic [31:0] word_t;

    // Segment selectors and bases.
    typedef logic [15:0] seg_t;

    typedef logic [19:0] lim_t;
    typedef logic [2:0]  reg_idx_t;

    // Size code: byte, word, dword, quad.
    typedef logic [1:0]  opsize_t;
    typedef logic [1:0]  scale_t;

endpackage

`default_nettype wire
